//--- oadc_testdata.txt
// op a b in hex: 1 write addr data, 2 read addr expect, 3 status bits leds, 4 source
// 5 freq spacing count, 6 led periods, 7 pwm gain, 8 counter n, 9 adc n, a arm level sample
1 0 5a
1 1 1
1 2 c3
1 3 fb     // only low nibble kept
1 4 1
2 0 5a
2 1 1
2 2 c3
2 3 b
2 4 1
2 7 0      // unmapped
9 100 0    // adc source is on
6 200 100
1 1 0
3 5 1
2 5 7
3 a 2
2 5 10
1 1 2      // mode 10 acts like 00
3 3 3
5 80 4
7 5a 0
1 0 0
7 0 0
1 0 ff
7 ff 0
1 0 1
7 1 0
4 0 0
8 200 0
a 400 0    // less-than, fires on wrap
a a00 a01  // greater-than
a 123 0
a 8ff 900

//--- oadc_top.f
oadc_pkg.sv
cfg_if.sv
oadc_registers.sv
panel_control.sv
adc_level_trigger.sv
oadc_top.sv
tb_oadc_top.sv

//--- Makefile
TOP = tb_oadc_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f oadc_top.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

//--- tb_oadc_top.sv
`timescale 1ns/1ps

module tb_oadc_top;
   import oadc_pkg::*;

   localparam int hb_width_sim = 10;
   localparam int max_ops      = 64;

   logic      clk_usb;
   logic      reset;
   reg_addr_t reg_address_i;
   reg_data_t reg_datai_i;
   logic      reg_read_i;
   logic      reg_write_i;
   reg_data_t reg_datao_o;
   sample_t   adc_data_i;
   logic      armed_i;
   logic      capture_active_i;
   logic      armed_and_ready_i;
   logic      dut_trigger_i;
   logic      pll_status_i;
   logic      led_armed_o;
   logic      led_capture_o;
   logic      freq_measure_o;
   logic      amp_gain_o;
   sample_t   adc_sample_o;
   logic      trigger_adc_o;

   logic [15:0] testdata [0:3*max_ops-1];   // op, a, b per line
   logic [31:0] rng_state = 32'h96c9242d;
   int          cycle_count;
   int          cycle_limit;

   oadc_top #(
      .hb_width          (hb_width_sim)
   ) oadc_top_inst (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .reg_address_i     (reg_address_i),
      .reg_datai_i       (reg_datai_i),
      .reg_read_i        (reg_read_i),
      .reg_write_i       (reg_write_i),
      .reg_datao_o       (reg_datao_o),
      .adc_data_i        (adc_data_i),
      .armed_i           (armed_i),
      .capture_active_i  (capture_active_i),
      .armed_and_ready_i (armed_and_ready_i),
      .dut_trigger_i     (dut_trigger_i),
      .pll_status_i      (pll_status_i),
      .led_armed_o       (led_armed_o),
      .led_capture_o     (led_capture_o),
      .freq_measure_o    (freq_measure_o),
      .amp_gain_o        (amp_gain_o),
      .adc_sample_o      (adc_sample_o),
      .trigger_adc_o     (trigger_adc_o)
   );

   initial begin
      clk_usb = 1'b0;
      forever #2 clk_usb = ~clk_usb;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Regression failed");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
         abort_run($sformatf("** Error at %0d ns: %s = 0x%0h, expected 0x%0h",
                             $time, name, got, expected));
   endtask

   task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
      @(negedge clk_usb);
      reg_address_i = addr;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      @(negedge clk_usb);
      reg_write_i   = 1'b0;
   endtask

   task automatic read_reg_expect(input reg_addr_t addr, input reg_data_t expected);
      @(negedge clk_usb);
      reg_address_i = addr;
      reg_read_i    = 1'b1;
      @(negedge clk_usb);
      reg_read_i    = 1'b0;
      check_equal($sformatf("reg_datao_o[addr %0h]", addr), 32'(reg_datao_o), 32'(expected));
   endtask

   // bit 0 armed, 1 capture active, 2 dut trigger, 3 pll status
   task automatic set_status(input logic [3:0] bits, input logic [1:0] leds_expect);
      @(negedge clk_usb);
      armed_i          = bits[0];
      capture_active_i = bits[1];
      dut_trigger_i    = bits[2];
      pll_status_i     = bits[3];
      @(negedge clk_usb);
      check_equal("led_armed_o", 32'(led_armed_o), 32'(leds_expect[0]));
      check_equal("led_capture_o", 32'(led_capture_o), 32'(leds_expect[1]));
   endtask

   task automatic select_source(input logic use_adc);
      write_reg(addr_source, {7'b0, use_adc});
      repeat (3) @(negedge clk_usb);   // register plus two sample stages
   endtask

   task automatic measure_freq(input int spacing, input int intervals);
      int gap;
      int n;
      @(negedge clk_usb);
      while (freq_measure_o !== 1'b1) @(negedge clk_usb);
      for (n = 0; n < intervals; n++) begin
         @(negedge clk_usb);
         gap = 1;
         check_equal("freq_measure_o", 32'(freq_measure_o), 32'd0);
         while (freq_measure_o !== 1'b1) begin
            @(negedge clk_usb);
            gap++;
         end
         check_equal("freq_measure_o spacing", gap, spacing);
      end
   endtask

   // led mode 01 gives square waves of the given periods
   task automatic watch_led_toggles(input int armed_period, input int capture_period);
      int   armed_run;
      int   capture_run;
      int   armed_flips;
      int   capture_flips;
      logic armed_prev;
      logic capture_prev;
      armed_run     = 0;
      capture_run   = 0;
      armed_flips   = 0;
      capture_flips = 0;
      @(negedge clk_usb);
      armed_prev   = led_armed_o;
      capture_prev = led_capture_o;
      repeat (2 * armed_period) begin
         @(negedge clk_usb);
         armed_run++;
         capture_run++;
         if (led_armed_o !== armed_prev) begin
            if (armed_flips > 0)
               check_equal("led_armed_o half period", armed_run, armed_period / 2);
            armed_flips++;
            armed_run = 0;
         end
         if (led_capture_o !== capture_prev) begin
            if (capture_flips > 0)
               check_equal("led_capture_o half period", capture_run, capture_period / 2);
            capture_flips++;
            capture_run = 0;
         end
         armed_prev   = led_armed_o;
         capture_prev = led_capture_o;
      end
      check_equal("led_armed_o toggles", armed_flips, 4);
      check_equal("led_capture_o toggles", capture_flips, 4 * armed_period / capture_period);
   endtask

   // count carries in every 256 cycle window
   task automatic check_pwm(input int gain);
      logic highs [0:511];
      int   ones;
      int   k;
      repeat (2) @(negedge clk_usb);
      for (k = 0; k < 512; k++) begin
         @(negedge clk_usb);
         highs[k] = amp_gain_o;
      end
      ones = 0;
      for (k = 0; k < 256; k++)
         if (highs[k]) ones++;
      check_equal("amp_gain_o highs", ones, gain);
      for (k = 1; k <= 256; k++) begin
         if (highs[k+255]) ones++;
         if (highs[k-1]) ones--;
         check_equal("amp_gain_o highs", ones, gain);
      end
   endtask

   task automatic check_counter_samples(input int count);
      sample_t prev_s;
      sample_t next_s;
      int      k;
      @(negedge clk_usb);
      prev_s = adc_sample_o;
      for (k = 0; k < count; k++) begin
         @(negedge clk_usb);
         next_s = prev_s + 12'd1;
         check_equal("adc_sample_o", 32'(adc_sample_o), 32'(next_s));
         prev_s = adc_sample_o;
      end
   endtask

   task automatic check_adc_samples(input int count);
      sample_t driven [$];
      sample_t value;
      sample_t oldest;
      int      k;
      for (k = 0; k < count; k++) begin
         @(negedge clk_usb);
         if (driven.size() == 2) begin
            oldest = driven.pop_front();
            check_equal("adc_sample_o", 32'(adc_sample_o), 32'(oldest));
         end
         rng_state  = xorshift32(rng_state);
         value      = rng_state[11:0];
         adc_data_i = value;
         driven.push_back(value);
      end
   endtask

   // compare starts false with some margin before the level
   function automatic logic clear_of_level(input sample_t level, input sample_t s);
      if (level[11])
         return int'(s) + 16 <= int'(level);
      else
         return int'(s) >= int'(level) && int'(s) + 16 <= 4095;
   endfunction

   task automatic arm_and_expect(input sample_t level, input sample_t expected);
      sample_t prev_s;
      write_reg(addr_trig_level_lo, level[7:0]);
      write_reg(addr_trig_level_hi, {4'b0, level[11:8]});
      @(negedge clk_usb);
      while (!clear_of_level(level, adc_sample_o)) @(negedge clk_usb);
      armed_and_ready_i = 1'b1;
      prev_s = adc_sample_o;
      @(negedge clk_usb);
      while (trigger_adc_o !== 1'b1) begin
         prev_s = adc_sample_o;   // sample seen by the registered compare
         @(negedge clk_usb);
      end
      check_equal("trigger sample", 32'(prev_s), 32'(expected));
      repeat (4096 + 16) begin   // no re-arm over a full counter wrap
         @(negedge clk_usb);
         check_equal("trigger_adc_o", 32'(trigger_adc_o), 32'd0);
      end
      armed_and_ready_i = 1'b0;
      @(negedge clk_usb);
   endtask

   function automatic int op_cost(input int op, input int a, input int b);
      case (op)
         1:       return 2;
         2:       return 3;
         3:       return 2;
         4:       return 6;
         5:       return a * (b + 2);
         6:       return 2 * a + 2;
         7:       return 516;
         8, 9:    return a + 2;
         10:      return 3 * 4096 + 32;
         default: return 1;
      endcase
   endfunction

   task automatic run_op(input int idx);
      logic [15:0] op;
      logic [15:0] a;
      logic [15:0] b;
      op = testdata[3*idx];
      a  = testdata[3*idx+1];
      b  = testdata[3*idx+2];
      case (op)
         16'h1:   write_reg(a[7:0], b[7:0]);
         16'h2:   read_reg_expect(a[7:0], b[7:0]);
         16'h3:   set_status(a[3:0], b[1:0]);
         16'h4:   select_source(a[0]);
         16'h5:   measure_freq(int'(a), int'(b));
         16'h6:   watch_led_toggles(int'(a), int'(b));
         16'h7:   check_pwm(int'(a[7:0]));
         16'h8:   check_counter_samples(int'(a));
         16'h9:   check_adc_samples(int'(a));
         16'ha:   arm_and_expect(a[11:0], b[11:0]);
         default: abort_run($sformatf("unknown operation %0h in test data entry %0d", op, idx));
      endcase
   endtask

   initial begin
      cycle_count = 0;
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk_usb);
         cycle_count++;
      end
      abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
   end

   initial begin
      int i;
      int n_ops;
      int budget;
      reset             = 1'b1;
      reg_address_i     = '0;
      reg_datai_i       = '0;
      reg_read_i        = 1'b0;
      reg_write_i       = 1'b0;
      adc_data_i        = '0;
      armed_i           = 1'b0;
      capture_active_i  = 1'b0;
      armed_and_ready_i = 1'b0;
      dut_trigger_i     = 1'b0;
      pll_status_i      = 1'b0;
      for (i = 0; i < 3 * max_ops; i++)
         testdata[i] = '0;
      $readmemh("oadc_testdata.txt", testdata);
      n_ops  = 0;
      budget = 0;
      while (n_ops < max_ops && testdata[3*n_ops] != 16'h0) begin
         budget += op_cost(int'(testdata[3*n_ops]), int'(testdata[3*n_ops+1]),
                           int'(testdata[3*n_ops+2]));
         n_ops++;
      end
      if (n_ops == 0)
         abort_run("no operations read from oadc_testdata.txt");
      else begin
         cycle_limit = 4 * budget + 2 ** 12;
         repeat (4) @(posedge clk_usb);
         @(negedge clk_usb);
         reset = 1'b0;
         for (i = 0; i < n_ops; i++)
            run_op(i);
         $display("Regression passed");
         $finish;
      end
   end

endmodule

//--- oadc_top.sv
`timescale 1ns/1ps

module oadc_top #(
   parameter int hb_width = oadc_pkg::hb_width_default  // 8 to 32
) (
   input  logic                clk_usb,
   input  logic                reset,

   // register port
   input  oadc_pkg::reg_addr_t reg_address_i,
   input  oadc_pkg::reg_data_t reg_datai_i,
   input  logic                reg_read_i,
   input  logic                reg_write_i,
   output oadc_pkg::reg_data_t reg_datao_o,

   // adc and capture status
   input  oadc_pkg::sample_t   adc_data_i,
   input  logic                armed_i,
   input  logic                capture_active_i,
   input  logic                armed_and_ready_i,
   input  logic                dut_trigger_i,
   input  logic                pll_status_i,

   // front panel
   output logic                led_armed_o,
   output logic                led_capture_o,
   output logic                freq_measure_o,
   output logic                amp_gain_o,

   output oadc_pkg::sample_t   adc_sample_o,
   output logic                trigger_adc_o
);

   cfg_if cfg_bus ();

   assign cfg_bus.armed_and_ready = armed_and_ready_i;

   oadc_registers registers_inst (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .reg_address_i    (reg_address_i),
      .reg_datai_i      (reg_datai_i),
      .reg_read_i       (reg_read_i),
      .reg_write_i      (reg_write_i),
      .reg_datao_o      (reg_datao_o),
      .armed_i          (armed_i),
      .capture_active_i (capture_active_i),
      .dut_trigger_i    (dut_trigger_i),
      .pll_status_i     (pll_status_i),
      .cfg              (cfg_bus.regs)
   );

   panel_control #(
      .hb_width         (hb_width)
   ) panel_inst (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .armed_i          (armed_i),
      .capture_active_i (capture_active_i),
      .led_armed_o      (led_armed_o),
      .led_capture_o    (led_capture_o),
      .freq_measure_o   (freq_measure_o),
      .amp_gain_o       (amp_gain_o),
      .cfg              (cfg_bus.panel)
   );

   adc_level_trigger trigger_inst (
      .clk_usb          (clk_usb),
      .reset            (reset),
      .adc_data_i       (adc_data_i),
      .adc_sample_o     (adc_sample_o),
      .trigger_adc_o    (trigger_adc_o),
      .cfg              (cfg_bus.trigger)
   );

endmodule

//--- adc_level_trigger.sv
`timescale 1ns/1ps

module adc_level_trigger (
   input  logic              clk_usb,
   input  logic              reset,

   input  oadc_pkg::sample_t adc_data_i,
   output oadc_pkg::sample_t adc_sample_o,
   output logic              trigger_adc_o,

   cfg_if.trigger            cfg
);
   import oadc_pkg::*;

   sample_t     test_count;
   sample_t     sample_pre;
   logic        arm_r;
   logic        arm_edge;
   logic        level_hit;
   trig_state_t state;

   always_ff @(posedge clk_usb) begin
      if (reset)
         test_count <= '0;
      else
         test_count <= test_count + sample_t'(1);
   end

   // two register delay matches the capture path
   always_ff @(posedge clk_usb) begin
      sample_pre   <= cfg.use_adc ? adc_data_i : test_count;
      adc_sample_o <= sample_pre;
   end

   assign arm_edge = cfg.armed_and_ready & ~arm_r;

   // level bit 11 set means fire above the level
   assign level_hit = cfg.trig_level[11] ? (adc_sample_o > cfg.trig_level)
                                         : (adc_sample_o < cfg.trig_level);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state         <= trig_idle;
         arm_r         <= 1'b0;
         trigger_adc_o <= 1'b0;
      end
      else begin
         arm_r <= cfg.armed_and_ready;
         case (state)
            trig_idle: begin
               trigger_adc_o <= 1'b0;
               if (arm_edge)
                  state <= trig_watch;
            end
            trig_watch: begin
               // hold off the compare once the pulse is out
               trigger_adc_o <= level_hit & ~trigger_adc_o;
               if (trigger_adc_o)
                  state <= trig_idle;
            end
            default: begin
               trigger_adc_o <= 1'b0;
               state         <= trig_idle;
            end
         endcase
      end
   end

   trig_one_cycle: assert property (
      @(posedge clk_usb) disable iff (reset)
      trigger_adc_o |=> !trigger_adc_o
   ) else $error("trigger_adc_o wider than one cycle");

   trig_only_watching: assert property (
      @(posedge clk_usb) disable iff (reset)
      trigger_adc_o |-> state == trig_watch
   ) else $error("trigger_adc_o fired while idle");

endmodule

//--- panel_control.sv
`timescale 1ns/1ps

module panel_control #(
   parameter int hb_width = oadc_pkg::hb_width_default
) (
   input  logic  clk_usb,
   input  logic  reset,

   input  logic  armed_i,
   input  logic  capture_active_i,

   output logic  led_armed_o,
   output logic  led_capture_o,
   output logic  freq_measure_o,
   output logic  amp_gain_o,

   cfg_if.panel  cfg
);

   logic [hb_width-1:0] timer_hb;
   logic                hb_tap_r;     // delayed strobe tap for edge detect
   logic [8:0]          pwm_acc;

   // free running heartbeat, strobe on rising edge of tap bit
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_hb       <= '0;
         hb_tap_r       <= 1'b0;
         freq_measure_o <= 1'b0;
      end
      else begin
         timer_hb       <= timer_hb + hb_width'(1);
         hb_tap_r       <= timer_hb[hb_width-4];
         freq_measure_o <= timer_hb[hb_width-4] & ~hb_tap_r;
      end
   end

   // modes 10 and 11 fall back to status display
   always_comb begin
      if (cfg.led_select == 2'b01) begin
         led_armed_o   = timer_hb[hb_width-2];
         led_capture_o = timer_hb[hb_width-3];
      end
      else begin
         led_armed_o   = armed_i;
         led_capture_o = capture_active_i;
      end
   end

   // first order sigma-delta, carry out drives the gain pin
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, cfg.gain};
   end

   assign amp_gain_o = pwm_acc[8];

   strobe_single_cycle: assert property (
      @(posedge clk_usb) disable iff (reset)
      freq_measure_o |=> !freq_measure_o
   ) else $error("freq_measure_o high for more than one cycle");

endmodule

//--- oadc_registers.sv
`timescale 1ns/1ps

module oadc_registers (
   input  logic                clk_usb,
   input  logic                reset,

   input  oadc_pkg::reg_addr_t reg_address_i,
   input  oadc_pkg::reg_data_t reg_datai_i,
   input  logic                reg_read_i,
   input  logic                reg_write_i,
   output oadc_pkg::reg_data_t reg_datao_o,

   input  logic                armed_i,
   input  logic                capture_active_i,
   input  logic                dut_trigger_i,
   input  logic                pll_status_i,

   cfg_if.regs                 cfg
);
   import oadc_pkg::*;

   gain_t     gain_q;
   led_sel_t  led_select_q;
   sample_t   trig_level_q;
   logic      use_adc_q;
   reg_data_t status_byte;
   reg_data_t read_data;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_q       <= '0;
         led_select_q <= '0;
         trig_level_q <= '0;
         use_adc_q    <= 1'b0;
      end
      else if (reg_write_i) begin
         case (reg_address_i)
            addr_gain:          gain_q             <= reg_datai_i;
            addr_led_select:    led_select_q       <= reg_datai_i[1:0];
            addr_trig_level_lo: trig_level_q[7:0]  <= reg_datai_i;
            addr_trig_level_hi: trig_level_q[11:8] <= reg_datai_i[3:0];
            addr_source:        use_adc_q          <= reg_datai_i[0];
            default: ;                               // status and unmapped
         endcase
      end
   end

   assign cfg.gain       = gain_q;
   assign cfg.led_select = led_select_q;
   assign cfg.trig_level = trig_level_q;
   assign cfg.use_adc    = use_adc_q;

   // armed, not capturing, dut trigger, pll lock
   assign status_byte = {3'b000, pll_status_i, 1'b0, dut_trigger_i,
                         ~capture_active_i, armed_i};

   always_comb begin
      case (reg_address_i)
         addr_gain:          read_data = gain_q;
         addr_led_select:    read_data = {6'b0, led_select_q};
         addr_trig_level_lo: read_data = trig_level_q[7:0];
         addr_trig_level_hi: read_data = {4'b0, trig_level_q[11:8]};
         addr_source:        read_data = {7'b0, use_adc_q};
         addr_status:        read_data = status_byte;
         default:            read_data = '0;
      endcase
   end

   // read data holds until the next read strobe
   always_ff @(posedge clk_usb) begin
      if (reset)
         reg_datao_o <= '0;
      else if (reg_read_i)
         reg_datao_o <= read_data;
   end

   // host never overlaps a read with a write
   rd_wr_exclusive: assert property (
      @(posedge clk_usb) disable iff (reset)
      !(reg_read_i && reg_write_i)
   ) else $error("register read and write strobes high together");

endmodule

//--- cfg_if.sv
`timescale 1ns/1ps

interface cfg_if;
   import oadc_pkg::*;

   gain_t    gain;
   led_sel_t led_select;
   sample_t  trig_level;      // bit 11 picks greater-than
   logic     use_adc;         // else test counter
   logic     armed_and_ready;

   modport regs (
      output gain,
      output led_select,
      output trig_level,
      output use_adc
   );

   modport panel (
      input gain,
      input led_select
   );

   modport trigger (
      input trig_level,
      input use_adc,
      input armed_and_ready
   );

endinterface

//--- oadc_pkg.sv
package oadc_pkg;

   // bus and datapath widths
   typedef logic [7:0]  reg_addr_t;
   typedef logic [7:0]  reg_data_t;
   typedef logic [11:0] sample_t;
   typedef logic [7:0]  gain_t;     // pwm increment per cycle
   typedef logic [1:0]  led_sel_t;

   // single-shot adc level trigger
   typedef enum logic {
      trig_idle,   // waiting for next arm edge
      trig_watch   // comparing samples against level
   } trig_state_t;

   // register map
   localparam reg_addr_t addr_gain          = 8'd0;
   localparam reg_addr_t addr_led_select    = 8'd1;
   localparam reg_addr_t addr_trig_level_lo = 8'd2;
   localparam reg_addr_t addr_trig_level_hi = 8'd3; // only bits 3:0 stored
   localparam reg_addr_t addr_source        = 8'd4; // bit 0 selects adc input
   localparam reg_addr_t addr_status        = 8'd5; // read only

   // heartbeat counter width on hardware
   localparam int hb_width_default = 26;

endpackage
